/* flist.f */
+incdir+rtl
rtl/zc_pkg.sv
rtl/fetch_skid_buffer.sv
rtl/zc_sequencer.sv
rtl/decode_out_reg.sv
rtl/zc_expander_top.sv
tests/zc_expander_tb.sv

/* rtl/decode_out_reg.sv */
/*
 * Decode-side output register, a full-throughput valid/ready stage
 */
`timescale 1ns/100ps
`default_nettype none

module decode_out_reg (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             in_valid_i,
  input  wire zc_pkg::dec_pkt_t in_pkt_i,
  output logic                  in_ready_o,
  output logic                  out_valid_o,
  output zc_pkg::dec_pkt_t      out_pkt_o,
  input  wire logic             out_ready_i
);

  import zc_pkg::*;

  // Held operation
  dec_pkt_t pkt_q;
  logic     valid_q;
  logic     load;

  ////////////////////////////////////////////////////////////
  // Stage control
  ////////////////////////////////////////////////////////////

  // Free when empty or when the held entry leaves this cycle
  assign in_ready_o = !valid_q || out_ready_i;
  assign load       = in_valid_i && in_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      // Refill or drain
      valid_q <= in_valid_i;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (load) begin
      pkt_q <= in_pkt_i;
    end
  end

  // Both outputs come straight from flops
  assign out_valid_o = valid_q;
  assign out_pkt_o   = pkt_q;

endmodule

`default_nettype wire

/* rtl/fetch_skid_buffer.sv */
/*
 * Fetch skid buffer holding up to ZC_SKID_DEPTH packets so fetch keeps
 * streaming while a multi-operation sequence drains
 */
`timescale 1ns/100ps
`default_nettype none

`include "zc_settings.svh"

module fetch_skid_buffer (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               in_valid_i,
  input  wire zc_pkg::fetch_pkt_t in_pkt_i,
  output logic                    in_ready_o,
  output logic                    out_valid_o,
  output zc_pkg::fetch_pkt_t      out_pkt_o,
  input  wire logic               out_ready_i
);

  import zc_pkg::*;

  localparam int unsigned PTR_W = (`ZC_SKID_DEPTH > 1) ? $clog2(`ZC_SKID_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(`ZC_SKID_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`ZC_SKID_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(`ZC_SKID_DEPTH);

  // Circular store
  fetch_pkt_t       store_q [`ZC_SKID_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] fill_q;
  logic             push;
  logic             pop;

  // Pointer step with wrap at the last entry
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
  endfunction

  // Ready comes straight from the fill count, never from out_ready_i
  assign in_ready_o  = (fill_q != FULL_CNT);
  assign out_valid_o = (fill_q != '0);
  assign out_pkt_o   = store_q[rd_ptr_q];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      fill_q <= fill_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Payload storage
  always_ff @(posedge clk) begin
    if (push) begin
      store_q[wr_ptr_q] <= in_pkt_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/zc_expander_top.sv */
/*
 * Zc expander top with fetch skid buffer, sequencer and decode output register
 */
`timescale 1ns/100ps
`default_nettype none

module zc_expander_top (
  input  wire logic               clk,
  input  wire logic               rst_n,
  // Fetch side
  input  wire logic               fetch_valid_i,
  input  wire zc_pkg::fetch_pkt_t fetch_pkt_i,
  output logic                    fetch_ready_o,
  // Decode side
  output logic                    dec_valid_o,
  output zc_pkg::dec_pkt_t        dec_pkt_o,
  input  wire logic               dec_ready_i
);

  import zc_pkg::*;

  // Buffer to sequencer
  logic       held_valid;
  fetch_pkt_t held_pkt;
  logic       held_ready;

  // Sequencer to output register
  logic       op_valid;
  dec_pkt_t   op_pkt;
  logic       op_ready;

  fetch_skid_buffer i_skid (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (fetch_valid_i),
    .in_pkt_i    (fetch_pkt_i),
    .in_ready_o  (fetch_ready_o),
    .out_valid_o (held_valid),
    .out_pkt_o   (held_pkt),
    .out_ready_i (held_ready)
  );

  zc_sequencer i_seq (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (held_valid),
    .instr_pkt_i   (held_pkt),
    .instr_ready_o (held_ready),
    .op_valid_o    (op_valid),
    .op_pkt_o      (op_pkt),
    .op_ready_i    (op_ready)
  );

  // Cuts the path from the buffer through operation build
  decode_out_reg i_out (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid_i  (op_valid),
    .in_pkt_i    (op_pkt),
    .in_ready_o  (op_ready),
    .out_valid_o (dec_valid_o),
    .out_pkt_o   (dec_pkt_o),
    .out_ready_i (dec_ready_i)
  );

endmodule

`default_nettype wire

/* rtl/zc_pkg.sv */
/*
 * Zc expander types with packet structs, sequencer enums and
 * the rlist helper functions shared by the RTL and the testbench
 */
`default_nettype none

`include "zc_settings.svh"

package zc_pkg;

  ////////////////////////////////////////////////////////////
  // Packets
  ////////////////////////////////////////////////////////////

  // Fetch packet as it arrives from the fetch stage
  typedef struct packed {
    logic [`ZC_XLEN-1:0] word;
    logic                bus_err;
  } fetch_pkt_t;

  // Operation handed to decode
  typedef struct packed {
    logic [`ZC_XLEN-1:0] word;
    logic                bus_err;
    // Final operation of its sequence
    logic                last;
  } dec_pkt_t;

  ////////////////////////////////////////////////////////////
  // Sequencer enums
  ////////////////////////////////////////////////////////////

  // Decoded kind of the held instruction
  typedef enum logic [2:0] {
    NONE,
    PUSH,
    POP,
    POPRET,
    POPRETZ,
    MVA01S,
    MVSA01
  } seq_kind_e;

  // Position inside an expanded sequence
  typedef enum logic [2:0] {
    S_IDLE,
    S_PUSH,
    S_POP,
    S_RA,
    S_SP,
    S_A0,
    S_RET,
    S_DMOVE
  } seq_state_e;

  // Operation counter within one sequence
  typedef logic [3:0] seq_cnt_t;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Saved-register index to architectural number
  // s0 and s1 sit at x8/x9, s2 to s11 at x18 to x27
  function automatic logic [4:0] sreg_to_regnum(input logic [3:0] sidx);
    logic [4:0] num;
    if (sidx < 4'd2) begin
      num = 5'd8 + {1'b0, sidx};
    end else begin
      num = 5'd16 + {1'b0, sidx};
    end
    return num;
  endfunction

  // Number of s registers covered by an rlist
  function automatic logic [3:0] rlist_reg_count(input logic [3:0] rlist);
    logic [3:0] cnt;
    if (rlist == 4'd15) begin
      // rlist 15 skips s10 alone and saves s0 to s11
      cnt = 4'd12;
    end else if (rlist >= 4'd5) begin
      cnt = rlist - 4'd4;
    end else begin
      cnt = 4'd0;
    end
    return cnt;
  endfunction

  // Stack bytes for ra plus saved registers, 16-byte aligned
  function automatic logic [11:0] rlist_stack_base(input logic [3:0] rlist);
    logic [11:0] bytes;
    bytes = (12'(rlist_reg_count(rlist)) + 12'd1) << 2;
    return (bytes + 12'd15) & 12'hff0;
  endfunction

endpackage

`default_nettype wire

/* rtl/zc_sequencer.sv */
/*
 * Zc sequencer that expands cm.push/pop/popret/popretz and cm.mva01s/mvsa01
 * into plain 32-bit operations, one per downstream handshake
 */
`timescale 1ns/100ps
`default_nettype none

`include "zc_settings.svh"

module zc_sequencer (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               instr_valid_i,
  input  wire zc_pkg::fetch_pkt_t instr_pkt_i,
  output logic                    instr_ready_o,
  output logic                    op_valid_o,
  output zc_pkg::dec_pkt_t        op_pkt_o,
  input  wire logic               op_ready_i
);

  import zc_pkg::*;

  // Fields of the held word
  logic [`ZC_XLEN-1:0] word;
  logic [3:0]          rlist;
  logic [1:0]          spimm;
  logic [2:0]          r1s;
  logic [2:0]          r2s;

  // Decode results
  seq_kind_e           kind;
  logic                is_load;
  logic [3:0]          reg_cnt;
  logic [11:0]         stack_total;

  // FSM and counter
  seq_state_e          state_q;
  seq_state_e          state_d;
  seq_state_e          start_state;
  seq_state_e          cur_state;
  seq_cnt_t            cnt_q;

  // Operation build
  logic [11:0]         slot_off;
  logic [11:0]         cur_off;
  logic [3:0]          sreg_idx;
  logic [4:0]          sreg_num;
  logic [4:0]          mv_snum;
  logic [4:0]          mv_areg;
  logic [`ZC_XLEN-1:0] op_word;
  logic                last;
  logic                fire;

  assign word  = instr_pkt_i.word;
  assign rlist = word[7:4];
  assign spimm = word[3:2];
  assign r1s   = word[9:7];
  assign r2s   = word[4:2];

  ////////////////////////////////////////////////////////////
  // Decode of the C2 sequenced encodings
  ////////////////////////////////////////////////////////////

  always_comb begin
    kind = NONE;
    // Bus errors always pass through untouched
    if (!instr_pkt_i.bus_err && word[1:0] == 2'b10 && word[15:13] == 3'b101) begin
      case (word[12:10])
        3'b011: begin
          // Double moves need two different s registers
          if (r1s != r2s) begin
            if (word[6:5] == 2'b11) begin
              kind = MVA01S;
            end else if (word[6:5] == 2'b01) begin
              kind = MVSA01;
            end
          end
        end
        3'b110: begin
          if (rlist >= 4'd4 && word[9:8] == 2'b00) begin
            kind = PUSH;
          end else if (rlist >= 4'd4 && word[9:8] == 2'b10) begin
            kind = POP;
          end
        end
        3'b111: begin
          if (rlist >= 4'd4 && word[9:8] == 2'b00) begin
            kind = POPRETZ;
          end else if (rlist >= 4'd4 && word[9:8] == 2'b10) begin
            kind = POPRET;
          end
        end
        default: begin
          kind = NONE;
        end
      endcase
    end
  end

  assign is_load = kind inside {POP, POPRET, POPRETZ};

  // Saved registers and total stack adjustment incl. spimm blocks of 16
  assign reg_cnt     = rlist_reg_count(rlist);
  assign stack_total = rlist_stack_base(rlist) + {6'd0, spimm, 4'd0};

  // Slot n of the frame sits at -(n+1)*4 from the old sp
  assign slot_off = (12'(cnt_q) + 12'd1) << 2;
  assign cur_off  = is_load ? (stack_total - slot_off) : (12'd0 - slot_off);

  // Highest s register goes first
  assign sreg_idx = reg_cnt - cnt_q - 4'd1;
  assign sreg_num = sreg_to_regnum(sreg_idx);

  // First move uses r1s and a0, second r2s and a1
  assign mv_snum = sreg_to_regnum({1'b0, (cnt_q[0] ? r2s : r1s)});
  assign mv_areg = cnt_q[0] ? `ZC_REG_A1 : `ZC_REG_A0;

  ////////////////////////////////////////////////////////////
  // Sequence FSM
  ////////////////////////////////////////////////////////////

  // Entry point of a new sequence
  always_comb begin
    case (kind)
      PUSH:                 start_state = (reg_cnt != 4'd0) ? S_PUSH : S_RA;
      POP, POPRET, POPRETZ: start_state = (reg_cnt != 4'd0) ? S_POP : S_RA;
      MVA01S, MVSA01:       start_state = S_DMOVE;
      default:              start_state = S_IDLE;
    endcase
  end

  // In S_IDLE the first operation is produced straight from decode
  assign cur_state = (state_q == S_IDLE) ? start_state : state_q;

  always_comb begin
    op_word = word;
    last    = 1'b0;
    state_d = cur_state;
    case (cur_state)
      S_PUSH: begin
        // sw s, off(sp)
        op_word = {cur_off[11:5], sreg_num, `ZC_REG_SP, 3'b010, cur_off[4:0], `ZC_OPC_STORE};
        if (cnt_q == reg_cnt - 4'd1) begin
          state_d = S_RA;
        end
      end
      S_POP: begin
        // lw s, off(sp)
        op_word = {cur_off, `ZC_REG_SP, 3'b010, sreg_num, `ZC_OPC_LOAD};
        if (cnt_q == reg_cnt - 4'd1) begin
          state_d = S_RA;
        end
      end
      S_RA: begin
        if (is_load) begin
          op_word = {cur_off, `ZC_REG_SP, 3'b010, `ZC_REG_RA, `ZC_OPC_LOAD};
        end else begin
          op_word = {cur_off[11:5], `ZC_REG_RA, `ZC_REG_SP, 3'b010, cur_off[4:0],
                     `ZC_OPC_STORE};
        end
        state_d = S_SP;
      end
      S_SP: begin
        // addi sp, sp, +/-total
        if (is_load) begin
          op_word = {stack_total, `ZC_REG_SP, 3'b000, `ZC_REG_SP, `ZC_OPC_OPIMM};
        end else begin
          op_word = {12'd0 - stack_total, `ZC_REG_SP, 3'b000, `ZC_REG_SP, `ZC_OPC_OPIMM};
        end
        if (kind == POPRETZ) begin
          state_d = S_A0;
        end else if (kind == POPRET) begin
          state_d = S_RET;
        end else begin
          last    = 1'b1;
          state_d = S_IDLE;
        end
      end
      S_A0: begin
        // addi a0, x0, 0
        op_word = {12'd0, 5'd0, 3'b000, `ZC_REG_A0, `ZC_OPC_OPIMM};
        state_d = S_RET;
      end
      S_RET: begin
        // jalr x0, 0(ra)
        op_word = {12'd0, `ZC_REG_RA, 3'b000, 5'd0, `ZC_OPC_JALR};
        last    = 1'b1;
        state_d = S_IDLE;
      end
      S_DMOVE: begin
        if (kind == MVSA01) begin
          op_word = {12'd0, mv_areg, 3'b000, mv_snum, `ZC_OPC_OPIMM};
        end else begin
          op_word = {12'd0, mv_snum, 3'b000, mv_areg, `ZC_OPC_OPIMM};
        end
        if (cnt_q[0]) begin
          last    = 1'b1;
          state_d = S_IDLE;
        end
      end
      default: begin
        // Pass-through as a single operation
        last    = 1'b1;
        state_d = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      cnt_q   <= '0;
    end else if (!instr_valid_i) begin
      // Nothing held, back to the start
      state_q <= S_IDLE;
      cnt_q   <= '0;
    end else if (fire) begin
      state_q <= state_d;
      cnt_q   <= last ? '0 : cnt_q + 4'd1;
    end
  end

  // Handshakes
  assign op_valid_o    = instr_valid_i;
  assign fire          = op_valid_o && op_ready_i;
  // Pop the buffer once, with the last operation
  assign instr_ready_o = fire && last;
  assign op_pkt_o      = '{word: op_word, bus_err: instr_pkt_i.bus_err, last: last};

endmodule

`default_nettype wire

/* rtl/zc_settings.svh */
/*
 * Zc expander settings for word widths, input buffer depth and fixed encodings
 */
`ifndef ZC_SETTINGS_SVH
`define ZC_SETTINGS_SVH

// Instruction word width
`define ZC_XLEN        32

// Entries held in the fetch-side buffer
`define ZC_SKID_DEPTH  2

// Base opcodes of the generated operations
`define ZC_OPC_LOAD    7'b0000011
`define ZC_OPC_STORE   7'b0100011
`define ZC_OPC_OPIMM   7'b0010011
`define ZC_OPC_JALR    7'b1100111

// Architectural register numbers used by the sequences
`define ZC_REG_RA      5'd1
`define ZC_REG_SP      5'd2
`define ZC_REG_A0      5'd10
`define ZC_REG_A1      5'd11

`endif

/* tests/zc_expander_tb.sv */
/*
 * Testbench for the Zc expander with a table-driven fetch stream checked against
 * a reference expansion model in a latency pass and a back-pressure pass
 */
`timescale 1ns/100ps
`default_nettype none

`include "zc_settings.svh"

module zc_expander_tb;

  import zc_pkg::*;

  localparam int N_ENTRIES       = 19;
  localparam int RESET_CYCLES    = 8;
  localparam int N_PASSES        = 2;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_PASSES * N_ENTRIES * 20;

  // Stimulus entry with fetch word, bus error flag and expected op count
  typedef struct packed {
    logic [31:0] word;
    logic        err;
    logic [4:0]  n_ops;
  } entry_t;

  logic       clk;
  logic       rst_n;
  logic       fetch_valid_i;
  fetch_pkt_t fetch_pkt_i;
  logic       fetch_ready_o;
  logic       dec_valid_o;
  dec_pkt_t   dec_pkt_o;
  logic       dec_ready_i;

  entry_t     stim [N_ENTRIES];
  dec_pkt_t   exp_q [$];
  int         fetch_cyc_q [$];
  int         cyc        = 0;
  int         ops_seen   = 0;
  int         last_cnt   = 0;
  logic       at_start   = 1'b1;
  logic       lat_mode   = 1'b0;
  logic       rand_ready = 1'b0;

  zc_expander_top i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_valid_i (fetch_valid_i),
    .fetch_pkt_i   (fetch_pkt_i),
    .fetch_ready_o (fetch_ready_o),
    .dec_valid_o   (dec_valid_o),
    .dec_pkt_o     (dec_pkt_o),
    .dec_ready_i   (dec_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("FAIL at %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // s0 and s1 live in x8 and x9 while s2 to s11 occupy x18 to x27
  function automatic logic [4:0] s_reg(input int idx);
    return (idx < 2) ? 5'(8 + idx) : 5'(18 + (idx - 2));
  endfunction

  // I-type word
  function automatic logic [31:0] enc_i(input int imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm[11:0], rs1, f3, rd, opc};
  endfunction

  // sw rs2, imm(sp)
  function automatic logic [31:0] enc_sw(input int imm, input logic [4:0] rs2);
    return {imm[11:5], rs2, `ZC_REG_SP, 3'b010, imm[4:0], `ZC_OPC_STORE};
  endfunction

  // Reference expansion of one fetch packet into the expected stream
  task automatic model_entry(input logic [31:0] w, input logic err, output int n_ops);
    logic [31:0] ops [$];
    dec_pkt_t    op;
    logic        zc;
    int          rl;
    int          nreg;
    int          total;
    int          r1;
    int          r2;
    int          i;
    rl    = w[7:4];
    r1    = w[9:7];
    r2    = w[4:2];
    nreg  = (rl == 15) ? 12 : ((rl >= 5) ? rl - 4 : 0);
    total = (((nreg + 1) * 4 + 15) / 16) * 16 + 16 * w[3:2];
    zc    = !err && w[1:0] == 2'b10 && w[15:13] == 3'b101;
    if (zc && rl >= 4 && w[12:8] == 5'b11000) begin
      // cm.push with the highest s register nearest the old sp
      for (i = 0; i < nreg; i++) begin
        ops.push_back(enc_sw(-4 * (i + 1), s_reg(nreg - 1 - i)));
      end
      ops.push_back(enc_sw(-4 * (nreg + 1), `ZC_REG_RA));
      ops.push_back(enc_i(-total, `ZC_REG_SP, 3'b000, `ZC_REG_SP, `ZC_OPC_OPIMM));
    end else if (zc && rl >= 4 && w[12:8] inside {5'b11010, 5'b11100, 5'b11110}) begin
      // cm.pop family whose loads mirror the push frame
      for (i = 0; i < nreg; i++) begin
        ops.push_back(enc_i(total - 4 * (i + 1), `ZC_REG_SP, 3'b010, s_reg(nreg - 1 - i),
                            `ZC_OPC_LOAD));
      end
      ops.push_back(enc_i(total - 4 * (nreg + 1), `ZC_REG_SP, 3'b010, `ZC_REG_RA,
                          `ZC_OPC_LOAD));
      ops.push_back(enc_i(total, `ZC_REG_SP, 3'b000, `ZC_REG_SP, `ZC_OPC_OPIMM));
      if (w[12:8] == 5'b11100) begin
        ops.push_back(enc_i(0, 5'd0, 3'b000, `ZC_REG_A0, `ZC_OPC_OPIMM));
      end
      if (w[12:8] != 5'b11010) begin
        ops.push_back(enc_i(0, `ZC_REG_RA, 3'b000, 5'd0, `ZC_OPC_JALR));
      end
    end else if (zc && w[12:10] == 3'b011 && w[6:5] == 2'b11 && r1 != r2) begin
      // cm.mva01s
      ops.push_back(enc_i(0, s_reg(r1), 3'b000, `ZC_REG_A0, `ZC_OPC_OPIMM));
      ops.push_back(enc_i(0, s_reg(r2), 3'b000, `ZC_REG_A1, `ZC_OPC_OPIMM));
    end else if (zc && w[12:10] == 3'b011 && w[6:5] == 2'b01 && r1 != r2) begin
      // cm.mvsa01
      ops.push_back(enc_i(0, `ZC_REG_A0, 3'b000, s_reg(r1), `ZC_OPC_OPIMM));
      ops.push_back(enc_i(0, `ZC_REG_A1, 3'b000, s_reg(r2), `ZC_OPC_OPIMM));
    end else begin
      ops.push_back(w);
    end
    n_ops = ops.size();
    for (i = 0; i < n_ops; i++) begin
      op.word    = ops[i];
      op.bus_err = err;
      op.last    = (i == n_ops - 1);
      exp_q.push_back(op);
    end
  endtask

  task automatic fill_table();
    stim[0]  = {32'h0000_B842, 1'b0, 5'd2};   // cm.push {ra}
    stim[1]  = {32'h0000_B856, 1'b0, 5'd3};   // cm.push {ra,s0}, spimm 1
    stim[2]  = {32'h0000_B8AA, 1'b0, 5'd8};   // cm.push rlist 10, spimm 2
    stim[3]  = {32'h0000_B8FE, 1'b0, 5'd14};  // cm.push {ra,s0-s11}, spimm 3
    stim[4]  = {32'h0000_BA62, 1'b0, 5'd4};   // cm.pop rlist 6
    stim[5]  = {32'h0000_BEF6, 1'b0, 5'd15};  // cm.popret rlist 15, spimm 1
    stim[6]  = {32'h0000_BC4A, 1'b0, 5'd4};   // cm.popretz {ra}, spimm 2
    stim[7]  = {32'h0000_BC92, 1'b0, 5'd9};   // cm.popretz rlist 9
    stim[8]  = {32'h0000_ACF6, 1'b0, 5'd2};   // cm.mva01s s1, s5
    stim[9]  = {32'h0000_AFA2, 1'b0, 5'd2};   // cm.mvsa01 s7, s0
    stim[10] = {32'h0000_ADEE, 1'b0, 5'd1};   // mva01s with equal regs
    stim[11] = {32'h0051_0093, 1'b0, 5'd1};   // addi x1, x2, 5
    stim[12] = {32'h0000_4501, 1'b0, 5'd1};   // c.li a0, 0
    stim[13] = {32'h0000_B82A, 1'b0, 5'd1};   // push with rlist 2
    stim[14] = {32'h0000_B872, 1'b1, 5'd1};   // push with bus error
    stim[15] = {32'h0000_BAC6, 1'b0, 5'd10};  // cm.pop rlist 12, spimm 1
    stim[16] = {32'h0000_BE5E, 1'b0, 5'd4};   // cm.popret rlist 5, spimm 3
    stim[17] = {32'h0000_BA32, 1'b0, 5'd1};   // pop with rlist 3
    stim[18] = {32'h1234_5678, 1'b1, 5'd1};   // plain word with bus error
  endtask

  // Offer one entry from a falling edge and hold it until accepted
  task automatic send_entry(input int idx);
    @(negedge clk);
    fetch_valid_i = 1'b1;
    fetch_pkt_i   = {stim[idx].word, stim[idx].err};
    @(posedge clk);
    while (!fetch_ready_o) begin
      @(posedge clk);
    end
  endtask

  task automatic idle_fetch();
    @(negedge clk);
    fetch_valid_i = 1'b0;
  endtask

  // Sequences count as done once their last operation has left
  task automatic wait_sequences(input int n_seq);
    while (last_cnt < n_seq) begin
      @(negedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Monitor
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin : monitor
    dec_pkt_t exp_op;
    cyc++;
    if (rst_n && lat_mode && fetch_valid_i && fetch_ready_o) begin
      fetch_cyc_q.push_back(cyc);
    end
    if (rst_n && dec_valid_o && dec_ready_i) begin
      check_val(exp_q.size() != 0, 1'b1, "operation beyond the expected stream");
      exp_op = exp_q.pop_front();
      check_val(dec_pkt_o, exp_op, $sformatf("operation %0d", ops_seen));
      // First op of a sequence leaves two edges after its fetch handshake
      if (at_start && lat_mode) begin
        check_val(cyc - fetch_cyc_q.pop_front(), 2, "fetch to decode latency");
      end
      at_start = dec_pkt_o.last;
      if (dec_pkt_o.last) begin
        last_cnt++;
      end
      ops_seen++;
    end
  end

  // Decode back-pressure that turns random in the second pass
  initial begin : backpressure
    void'($urandom(84));
    forever begin
      @(negedge clk);
      if (rand_ready) begin
        dec_ready_i = ($urandom % 3) != 0;
      end else begin
        dec_ready_i = 1'b1;
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, decode outputs stopped arriving (%0d seen)",
             WATCHDOG_CYCLES, ops_seen);
    $display("Simulation failed");
    $fatal(1);
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin : main
    int total;
    int n;
    rst_n         = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_pkt_i   = '0;
    dec_ready_i   = 1'b1;
    fill_table();
    total = 0;
    for (int p = 0; p < N_PASSES; p++) begin
      for (int i = 0; i < N_ENTRIES; i++) begin
        model_entry(stim[i].word, stim[i].err, n);
        check_val(n, stim[i].n_ops, $sformatf("model op count of entry %0d", i));
        total += n;
      end
    end
    repeat (RESET_CYCLES) @(posedge clk);
    check_val(dec_valid_o, 1'b0, "dec_valid_o in reset");
    check_val(fetch_ready_o, 1'b1, "fetch_ready_o in reset");
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_val(dec_valid_o, 1'b0, "dec_valid_o after reset");
    check_val(fetch_ready_o, 1'b1, "fetch_ready_o after reset");

    // Latency pass with one entry at a time and decode always ready
    lat_mode = 1'b1;
    for (int i = 0; i < N_ENTRIES; i++) begin
      send_entry(i);
      idle_fetch();
      wait_sequences(i + 1);
    end
    lat_mode   = 1'b0;
    rand_ready = 1'b1;

    // Streaming pass under back-pressure
    for (int i = 0; i < N_ENTRIES; i++) begin
      send_entry(i);
    end
    idle_fetch();
    wait_sequences(N_PASSES * N_ENTRIES);
    repeat (6) @(negedge clk);
    check_val(ops_seen, total, "total operations");
    check_val(last_cnt, N_PASSES * N_ENTRIES, "operations with last set");
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
